//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
TOP ?= tb_debug_top
FILELIST ?= compile.f
LOG ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, the simulator status alone is not trusted
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
source/debug_pkg.sv
source/async_fifo.sv
source/debug_link.sv
source/cmd_exec.sv
source/debug_top.sv
test/tb_debug_top.sv

//--- source/async_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module async_fifo #(
    // power of two, at least 4
    parameter int depth = 8
) (
    // write side
    input wire wclk,
    input wire arst_n,
    input wire w,
    input wire logic [debug_pkg::byte_w-1:0] wd,
    output logic wok,
    // read side
    input wire rclk,
    input wire r,
    output logic [debug_pkg::byte_w-1:0] rd,
    output logic rok
);

    localparam int addr_w = $clog2(depth);
    // one extra bit tells a full ring from an empty one
    localparam int ptr_w = addr_w + 1;

    function automatic logic [ptr_w-1:0] bin2gray(input logic [ptr_w-1:0] b);
        return b ^ (b >> 1);
    endfunction

    // storage, written from wclk and read asynchronously from rclk
    logic [debug_pkg::byte_w-1:0] mem [depth];

    // write domain pointers
    logic [ptr_w-1:0] wbin;
    logic [ptr_w-1:0] wgray;
    // read gray pointer seen from wclk
    logic [ptr_w-1:0] rgray_s1;
    logic [ptr_w-1:0] rgray_s2;

    // read domain pointers
    logic [ptr_w-1:0] rbin;
    logic [ptr_w-1:0] rgray;
    // write gray pointer seen from rclk
    logic [ptr_w-1:0] wgray_s1;
    logic [ptr_w-1:0] wgray_s2;

    // a stray write on a full ring is dropped, the assertion flags it
    wire wr_en = w && wok;
    wire rd_en = r && rok;
    wire [ptr_w-1:0] wbin_next = wbin + ptr_w'(wr_en);
    wire [ptr_w-1:0] rbin_next = rbin + ptr_w'(rd_en);

    // write side
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            wbin <= '0;
            wgray <= '0;
        end else begin
            wbin <= wbin_next;
            wgray <= bin2gray(wbin_next);
        end
    end

    always_ff @(posedge wclk) begin
        if (wr_en) begin
            mem[wbin[addr_w-1:0]] <= wd;
        end
    end

    // two flops, only one gray bit moves per step
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            rgray_s1 <= '0;
            rgray_s2 <= '0;
        end else begin
            rgray_s1 <= rgray;
            rgray_s2 <= rgray_s1;
        end
    end

    // full when the writer is one lap ahead
    // the stale read pointer only makes this pessimistic
    assign wok = (wgray != {~rgray_s2[ptr_w-1 -: 2], rgray_s2[ptr_w-3:0]});

    // read side
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            rbin <= '0;
            rgray <= '0;
        end else begin
            rbin <= rbin_next;
            rgray <= bin2gray(rbin_next);
        end
    end

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            wgray_s1 <= '0;
            wgray_s2 <= '0;
        end else begin
            wgray_s1 <= wgray;
            wgray_s2 <= wgray_s1;
        end
    end

    // empty when pointers meet, head word shown whenever not empty
    assign rok = (rgray != wgray_s2);
    assign rd = mem[rbin[addr_w-1:0]];

    // strobes must respect the ok levels seen by their own domain
    a_write_when_full: assert property (
        @(posedge wclk) disable iff (!arst_n) w |-> wok
    ) else $error("async_fifo: write strobe while full");

    a_read_when_empty: assert property (
        @(posedge rclk) disable iff (!arst_n) r |-> rok
    ) else $error("async_fifo: read strobe while empty");

endmodule

`default_nettype wire

//--- source/cmd_exec.sv
`default_nettype none
`timescale 1ns/10ps

module cmd_exec (
    input wire clk,
    input wire arst_n,
    // command FIFO read side
    output logic cmd_r,
    input wire debug_pkg::cmd_t cmd_rd,
    input wire cmd_rok,
    // reply FIFO write side
    output logic rsp_w,
    output debug_pkg::rsp_t rsp_wd,
    input wire rsp_wok,
    // LED outputs
    output logic [debug_pkg::led_count-1:0] led
);

    // command being executed this cycle
    // all zero means no-op, real commands carry the marker
    debug_pkg::cmd_t cur_cmd;

    // decode flags for cur_cmd
    logic do_write;
    logic do_read;

    // pop stage
    // hold off while a reply is being written, the FIFO might fill
    assign cmd_r = cmd_rok && rsp_wok && !rsp_w;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd <= '0;
        end else if (cmd_r) begin
            cur_cmd <= cmd_rd;
        end else begin
            cur_cmd <= '0;
        end
    end

    // decode stage
    always_comb begin
        do_write = 1'b0;
        do_read = 1'b0;
        if (cur_cmd.marker) begin
            case (cur_cmd.op)
                debug_pkg::op_led_write: do_write = 1'b1;
                debug_pkg::op_led_read: do_read = 1'b1;
                // unknown opcodes fall through as no-ops
                default: ;
            endcase
        end
    end

    // LED register, one bit per write command
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else if (do_write) begin
            led[cur_cmd.index] <= cur_cmd.value;
        end
    end

    // reply written on the execute edge
    // carries led before that edge, so earlier writes are included
    assign rsp_w = do_read;

    always_comb begin
        rsp_wd.marker = 1'b1;
        rsp_wd.rsvd = '0;
        rsp_wd.leds = led;
    end

    // room was checked at pop time, one cycle earlier
    a_rsp_has_room: assert property (
        @(posedge clk) disable iff (!arst_n) rsp_w |-> rsp_wok
    ) else $error("cmd_exec: reply written while reply FIFO full");

endmodule

`default_nettype wire

//--- source/debug_link.sv
`default_nettype none
`timescale 1ns/10ps

module debug_link (
    // serial side, all in debug_clk
    input wire debug_clk,
    input wire arst_n,
    input wire debug_cs,
    input wire debug_di,
    output logic debug_do,
    // command FIFO write side
    output logic cmd_w,
    output debug_pkg::cmd_t cmd_wd,
    input wire cmd_wok,
    // reply FIFO read side
    output logic rsp_r,
    input wire debug_pkg::rsp_t rsp_rd,
    input wire rsp_rok
);

    localparam int cnt_w = $clog2(debug_pkg::byte_w + 1);

    // incoming command, marker walks up to bit 7
    logic [debug_pkg::byte_w-1:0] cmd_sr;
    // set once the marker sits in the top bit
    wire cmd_ready = cmd_sr[debug_pkg::byte_w-1];

    // outgoing reply and bits left to send
    logic [debug_pkg::byte_w-1:0] rsp_sr;
    logic [cnt_w-1:0] rsp_cnt;
    wire rsp_busy = (rsp_cnt != '0);

    // command shifter
    // leading zeros just shift through until the marker arrives
    always_ff @(posedge debug_clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_sr <= '0;
            cmd_w <= 1'b0;
        end else begin
            // one-cycle write strobe
            cmd_w <= 1'b0;
            if (debug_cs) begin
                if (!cmd_ready) begin
                    cmd_sr <= {cmd_sr[debug_pkg::byte_w-2:0], debug_di};
                end else begin
                    // byte done, push it and take this bit as the next bit 0
                    cmd_w <= cmd_wok;
                    cmd_sr <= {{(debug_pkg::byte_w-1){1'b0}}, debug_di};
                end
            end
        end
    end

    // completed byte held for the FIFO write edge
    always_ff @(posedge debug_clk) begin
        if (debug_cs && cmd_ready) begin
            cmd_wd <= cmd_sr;
        end
    end

    // reply shifter
    // pop as soon as idle, the FIFO advances on this same edge
    assign rsp_r = !rsp_busy && rsp_rok;

    always_ff @(posedge debug_clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_cnt <= '0;
        end else if (rsp_r) begin
            rsp_cnt <= cnt_w'(debug_pkg::byte_w);
        end else if (rsp_busy && debug_cs) begin
            rsp_cnt <= rsp_cnt - 1'b1;
        end
    end

    // one bit per cs-high edge, MSB first
    always_ff @(posedge debug_clk) begin
        if (rsp_r) begin
            rsp_sr <= rsp_rd;
        end else if (rsp_busy && debug_cs) begin
            rsp_sr <= {rsp_sr[debug_pkg::byte_w-2:0], 1'b0};
        end
    end

    // low while idle, host skips zeros up to the marker
    assign debug_do = rsp_busy && rsp_sr[debug_pkg::byte_w-1];

    // executor must drain faster than the link fills
    // a finished byte with no room would be lost
    a_cmd_not_dropped: assert property (
        @(posedge debug_clk) disable iff (!arst_n)
        (debug_cs && cmd_ready) |-> cmd_wok
    ) else $error("debug_link: command dropped, command FIFO full");

endmodule

`default_nettype wire

//--- source/debug_pkg.sv
`default_nettype none

package debug_pkg;

    // serial byte width, commands and replies alike
    localparam int byte_w = 8;

    // board LEDs owned by the executor
    localparam int led_count = 4;

    // queue depths, powers of two for the gray pointers
    localparam int cmd_fifo_depth = 8;
    // reply queue deeper so several reads can pile up
    localparam int rsp_fifo_depth = 16;

    // opcodes carried in cmd_t.op
    // set or clear one LED
    localparam logic [2:0] op_led_write = 3'd0;
    // report all LED states
    localparam logic [2:0] op_led_read = 3'd1;
    // anything else decodes as a no-op

    // command byte, marker is the first meaningful bit on the wire
    // 0x80 and 0x81 land as LED 0 off and on
    typedef struct packed {
        // always 1, doubles as the ready flag in the shifter
        logic marker;
        // operation select
        logic [2:0] op;
        // LED number for op_led_write
        logic [$clog2(led_count)-1:0] index;
        // unused
        logic rsvd;
        // new LED level
        logic value;
    } cmd_t;

    // reply byte, shifted out MSB first
    typedef struct packed {
        // always 1 so the host can skip idle zeros
        logic marker;
        // zero
        logic [2:0] rsvd;
        // LED levels when the read executed
        logic [led_count-1:0] leds;
    } rsp_t;

endpackage

`default_nettype wire

//--- source/debug_top.sv
`default_nettype none
`timescale 1ns/10ps

module debug_top (
    // system side
    input wire clk,
    input wire arst_n,
    // host serial link
    input wire debug_clk,
    input wire debug_cs,
    input wire debug_di,
    output logic debug_do,
    // board LEDs
    output logic [debug_pkg::led_count-1:0] led
);

    // command path, debug_clk into clk
    wire cmd_w;
    wire debug_pkg::cmd_t cmd_wd;
    wire cmd_wok;
    wire cmd_r;
    wire debug_pkg::cmd_t cmd_rd;
    wire cmd_rok;

    // reply path, clk back into debug_clk
    wire rsp_w;
    wire debug_pkg::rsp_t rsp_wd;
    wire rsp_wok;
    wire rsp_r;
    wire debug_pkg::rsp_t rsp_rd;
    wire rsp_rok;

    // serial shifters
    debug_link u_link (
        .debug_clk(debug_clk),
        .arst_n(arst_n),
        .debug_cs(debug_cs),
        .debug_di(debug_di),
        .debug_do(debug_do),
        .cmd_w(cmd_w),
        .cmd_wd(cmd_wd),
        .cmd_wok(cmd_wok),
        .rsp_r(rsp_r),
        .rsp_rd(rsp_rd),
        .rsp_rok(rsp_rok)
    );

    // written by the link, drained by the executor
    async_fifo #(.depth(debug_pkg::cmd_fifo_depth)) u_cmd_fifo (
        .wclk(debug_clk),
        .arst_n(arst_n),
        .w(cmd_w),
        .wd(cmd_wd),
        .wok(cmd_wok),
        .rclk(clk),
        .r(cmd_r),
        .rd(cmd_rd),
        .rok(cmd_rok)
    );

    // read replies wait here until the link shifts them out
    async_fifo #(.depth(debug_pkg::rsp_fifo_depth)) u_rsp_fifo (
        .wclk(clk),
        .arst_n(arst_n),
        .w(rsp_w),
        .wd(rsp_wd),
        .wok(rsp_wok),
        .rclk(debug_clk),
        .r(rsp_r),
        .rd(rsp_rd),
        .rok(rsp_rok)
    );

    cmd_exec u_exec (
        .clk(clk),
        .arst_n(arst_n),
        .cmd_r(cmd_r),
        .cmd_rd(cmd_rd),
        .cmd_rok(cmd_rok),
        .rsp_w(rsp_w),
        .rsp_wd(rsp_wd),
        .rsp_wok(rsp_wok),
        .led(led)
    );

endmodule

`default_nettype wire

//--- test/tb_debug_top.sv
`default_nettype none
`timescale 1ns/10ps

module tb_debug_top;

    // retry limit for every wait in debug_clk cycles
    localparam int wait_limit = 200;
    localparam int bw = debug_pkg::byte_w;

    logic clk;
    logic arst_n;
    logic debug_clk;
    logic debug_cs;
    logic debug_di;
    wire debug_do;
    wire [debug_pkg::led_count-1:0] led;

    // random source state
    logic [15:0] lfsr_state;

    // model LED array and the replies still owed by the DUT
    logic [debug_pkg::led_count-1:0] model_led;
    logic [bw-1:0] model_rsp [$];

    int error_count;
    int timeout_count;
    int cmd_count;
    int rsp_count;

    // reply capture
    logic [bw-1:0] cap_sr;
    int cap_bits;

    debug_top UUT (
        .clk(clk),
        .arst_n(arst_n),
        .debug_clk(debug_clk),
        .debug_cs(debug_cs),
        .debug_di(debug_di),
        .debug_do(debug_do),
        .led(led)
    );

    // 20 ns system clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 34 ns host clock that never lines up with clk edges
    initial begin
        debug_clk = 1'b0;
        forever #17 debug_clk = ~debug_clk;
    end

    // 16-bit Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    // random fields around a fixed opcode
    function automatic debug_pkg::cmd_t make_cmd(input logic [2:0] op);
        debug_pkg::cmd_t c;
        c.marker = 1'b1;
        c.op = op;
        c.index = 2'(rand_bits(2));
        c.rsvd = 1'(rand_bits(1));
        c.value = 1'(rand_bits(1));
        return c;
    endfunction

    // a write sets one LED and a read owes a reply
    task automatic model_apply(input debug_pkg::cmd_t cmd);
        logic [bw-1:0] rsp;
        if (cmd.op == debug_pkg::op_led_write) begin
            model_led[cmd.index] = cmd.value;
        end else if (cmd.op == debug_pkg::op_led_read) begin
            // marker, three zero bits, LED levels
            rsp = {1'b1, 3'b000, model_led};
            model_rsp.push_back(rsp);
        end
    endtask

    // value held from 2 ns after this edge up to the next one
    task automatic drive_bit(input logic cs, input logic di);
        @(posedge debug_clk);
        #2;
        debug_cs = cs;
        debug_di = di;
    endtask

    // MSB first after the idle zeros, with optional cs-low gaps of junk data
    task automatic send_cmd(input debug_pkg::cmd_t cmd, input int lead, input logic gaps);
        int gap_len;
        for (int i = 0; i < lead; i++) begin
            drive_bit(1'b1, 1'b0);
        end
        for (int b = bw - 1; b >= 0; b--) begin
            if (gaps && rand_bits(2) == 0) begin
                gap_len = 1 + int'(rand_bits(2));
                repeat (gap_len) drive_bit(1'b0, 1'(rand_bits(1)));
            end
            drive_bit(1'b1, cmd[b]);
        end
        cmd_count++;
        model_apply(cmd);
    endtask

    // idle zeros keep the link moving and flush the last byte
    task automatic wait_led();
        int n;
        n = 0;
        while (led !== model_led && n < wait_limit) begin
            drive_bit(1'b1, 1'b0);
            n++;
        end
        assert (led === model_led) else begin
            $display("timeout: led stayed at %b while %b was expected", led, model_led);
            timeout_count++;
        end
    endtask

    // until every owed reply has been shifted out
    task automatic wait_replies();
        int n;
        n = 0;
        while ((model_rsp.size() != 0 || cap_bits != 0) && n < wait_limit) begin
            drive_bit(1'b1, 1'b0);
            n++;
        end
        assert (model_rsp.size() == 0) else begin
            $display("timeout: %0d replies never came back", model_rsp.size());
            timeout_count++;
        end
    endtask

    task automatic check_reply(input logic [bw-1:0] got);
        logic [bw-1:0] exp;
        rsp_count++;
        assert (model_rsp.size() != 0) else begin
            $display("an extra reply %h came out with no read pending", got);
            error_count++;
        end
        if (model_rsp.size() != 0) begin
            exp = model_rsp.pop_front();
            assert (got === exp) else begin
                $display("ERR %0t: reply %h, expected %h", $time, got, exp);
                error_count++;
            end
        end
    endtask

    // bit shown while cs is high leaves on the next rising edge
    always @(negedge debug_clk) begin
        if (arst_n && debug_cs) begin
            if (cap_bits == 0) begin
                // idle zeros skipped until a marker
                if (debug_do) begin
                    cap_sr = bw'(1);
                    cap_bits = 1;
                end
            end else begin
                cap_sr = {cap_sr[bw-2:0], debug_do};
                cap_bits++;
            end
            if (cap_bits == bw) begin
                check_reply(cap_sr);
                cap_bits = 0;
            end
        end
    end

    initial begin
        debug_pkg::cmd_t cmd;
        int unsigned r;
        lfsr_state = 16'd34541;
        error_count = 0;
        timeout_count = 0;
        cmd_count = 0;
        rsp_count = 0;
        model_led = '0;
        cap_sr = '0;
        cap_bits = 0;
        arst_n = 1'b0;
        debug_cs = 1'b0;
        debug_di = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // quiet after reset
        assert (led === '0) else begin
            $display("ERR %0t: led %b after reset, expected 0", $time, led);
            error_count++;
        end
        for (int i = 0; i < 20; i++) begin
            drive_bit(1'b1, 1'b0);
            assert (debug_do === 1'b0) else begin
                $display("ERR %0t: debug_do %b with no reply pending", $time, debug_do);
                error_count++;
            end
        end

        // reference bytes turn LED 0 on, off and on again
        send_cmd(8'h81, 2, 1'b0);
        wait_led();
        send_cmd(8'h80, 0, 1'b0);
        wait_led();
        send_cmd(8'h81, 0, 1'b0);
        wait_led();

        // random writes with clean framing
        for (int i = 0; i < 24; i++) begin
            send_cmd(make_cmd(debug_pkg::op_led_write), int'(rand_bits(2)), 1'b0);
            wait_led();
        end

        // longer zero runs and cs-low gaps inside bytes
        for (int i = 0; i < 24; i++) begin
            send_cmd(make_cmd(debug_pkg::op_led_write), int'(rand_bits(3)), 1'b1);
            wait_led();
        end

        // a write followed by a read of the new state
        for (int i = 0; i < 6; i++) begin
            send_cmd(make_cmd(debug_pkg::op_led_write), 0, 1'b0);
            send_cmd(make_cmd(debug_pkg::op_led_read), int'(rand_bits(1)), 1'b0);
            wait_led();
            wait_replies();
        end

        // unknown opcodes try to flip a LED and the read shows nothing moved
        for (int i = 0; i < 8; i++) begin
            cmd = make_cmd(3'(2 + rand_bits(3) % 6));
            cmd.value = ~model_led[cmd.index];
            send_cmd(cmd, int'(rand_bits(2)), 1'b0);
            send_cmd(make_cmd(debug_pkg::op_led_read), 0, 1'b0);
            wait_replies();
        end

        // back to back reads pile up in the reply queue
        for (int i = 0; i < 6; i++) begin
            send_cmd(make_cmd(debug_pkg::op_led_read), 0, 1'b0);
        end
        wait_replies();

        // long mix of half writes, a quarter reads and the rest unknown
        for (int i = 0; i < 300; i++) begin
            r = rand_bits(3);
            if (r < 4) begin
                cmd = make_cmd(debug_pkg::op_led_write);
            end else if (r < 6) begin
                cmd = make_cmd(debug_pkg::op_led_read);
            end else begin
                cmd = make_cmd(3'(2 + rand_bits(2)));
            end
            send_cmd(cmd, int'(rand_bits(2)), rand_bits(2) == 0);
            wait_led();
        end
        wait_replies();

        // room for any stray reply to show up
        repeat (40) drive_bit(1'b1, 1'b0);
        debug_cs = 1'b0;

        // the last command has executed by now
        assert (led === model_led) else begin
            $display("ERR %0t: final led %b, expected %b", $time, led, model_led);
            error_count++;
        end
        assert (cap_bits == 0) else begin
            $display("a reply was still half shifted out when the run ended");
            error_count++;
        end

        $display("commands %0d, replies %0d, errors %0d, timeouts %0d",
                 cmd_count, rsp_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
